// ==== include/udp_echo_cfg.svh ====
`ifndef UDP_ECHO_CFG_SVH
`define UDP_ECHO_CFG_SVH

// Destination port whose frames are echoed back
`define ECHO_PORT 16'd1234

// Reply headers that can wait for the transmit side
`define HDR_FIFO_DEPTH 4

// Payload bytes buffered between receive and transmit
`define PAYLOAD_FIFO_DEPTH 64

`endif

// ==== logic/byte_stream_pkg.sv ====
package byte_stream_pkg;

    // One payload byte with its framing flags
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } byte_beat_t;

endpackage

// ==== logic/first_byte_led.sv ====
`timescale 1ns/1ns

module first_byte_led (
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        beat_valid,
    input  logic                        beat_ready,
    input  byte_stream_pkg::byte_beat_t beat,

    output logic [7:0]                  led
);

    // Set when the next transferred beat opens a frame
    logic first_beat;
    logic beat_fire;

    assign beat_fire = beat_valid && beat_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            first_beat <= 1'b1;
            led        <= 8'h00;
        end else if (beat_fire) begin
            if (first_beat) begin
                led <= beat.data;
            end
            first_beat <= beat.last;
        end
    end

endmodule

// ==== logic/stream_fifo.sv ====
`timescale 1ns/1ns

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clock,
    input  logic reset,

    input  logic in_valid,
    input  T     in_item,
    output logic in_ready,

    output logic out_valid,
    output T     out_item,
    input  logic out_ready
);

    localparam int AW = $clog2(DEPTH);

    T mem [DEPTH];

    // Pointers carry one extra bit so full and empty can be told apart
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] rd_next;
    logic [AW:0] level;
    logic        full;
    logic        empty;
    logic        wr_fire;
    logic        rd_fire;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Items currently held
    assign level = wr_ptr - rd_ptr;

    // A slot freed by a read this cycle may be refilled at once
    assign in_ready  = !full || out_ready;
    assign out_valid = !empty;

    assign wr_fire = in_valid && in_ready;
    assign rd_fire = out_valid && out_ready;
    assign rd_next = rd_ptr + {{AW{1'b0}}, rd_fire};

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            mem[wr_ptr[AW-1:0]] <= in_item;
        end
    end

    // Head register, bypass when the new head is the item being written
    always_ff @(posedge clock) begin
        if (wr_fire && (wr_ptr == rd_next)) begin
            out_item <= in_item;
        end else begin
            out_item <= mem[rd_next[AW-1:0]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_next;
        end
    end

    // Occupancy never goes past the depth
    full_no_write: assert property (@(posedge clock) disable iff (reset)
        level <= DEPTH)
        else $error("stream_fifo: write accepted while full");

    // Held head item must not change under back-pressure
    out_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_item))
        else $error("stream_fifo: out_item changed while stalled");

endmodule

// ==== logic/udp_echo_top.sv ====
`timescale 1ns/1ns

`include "udp_echo_cfg.svh"

module udp_echo_top (
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        rx_hdr_valid,
    input  udp_hdr_pkg::udp_rx_hdr_t    rx_hdr,
    output logic                        rx_hdr_ready,

    input  logic                        rx_payload_valid,
    input  byte_stream_pkg::byte_beat_t rx_payload,
    output logic                        rx_payload_ready,

    output logic                        tx_hdr_valid,
    output udp_hdr_pkg::udp_tx_hdr_t    tx_hdr,
    input  logic                        tx_hdr_ready,

    output logic                        tx_payload_valid,
    output byte_stream_pkg::byte_beat_t tx_payload,
    input  logic                        tx_payload_ready,

    output logic [7:0]                  led
);

    import udp_hdr_pkg::*;
    import byte_stream_pkg::*;

    // Filter to header queue
    logic        reply_valid;
    logic        reply_ready;
    udp_tx_hdr_t reply;

    // Filter to payload queue
    logic        pass_valid;
    logic        pass_ready;
    byte_beat_t  pass_beat;

    udp_port_filter udp_port_filter_i (
        .clock         (clock),
        .reset         (reset),
        .hdr_valid     (rx_hdr_valid),
        .hdr           (rx_hdr),
        .hdr_ready     (rx_hdr_ready),
        .payload_valid (rx_payload_valid),
        .payload       (rx_payload),
        .payload_ready (rx_payload_ready),
        .reply_valid   (reply_valid),
        .reply         (reply),
        .reply_ready   (reply_ready),
        .pass_valid    (pass_valid),
        .pass_beat     (pass_beat),
        .pass_ready    (pass_ready)
    );

    // Several replies may queue up ahead of the transmit side
    stream_fifo #(
        .T     (udp_tx_hdr_t),
        .DEPTH (`HDR_FIFO_DEPTH)
    ) hdr_queue (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (reply_valid),
        .in_item   (reply),
        .in_ready  (reply_ready),
        .out_valid (tx_hdr_valid),
        .out_item  (tx_hdr),
        .out_ready (tx_hdr_ready)
    );

    stream_fifo #(
        .T     (byte_beat_t),
        .DEPTH (`PAYLOAD_FIFO_DEPTH)
    ) payload_queue (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (pass_valid),
        .in_item   (pass_beat),
        .in_ready  (pass_ready),
        .out_valid (tx_payload_valid),
        .out_item  (tx_payload),
        .out_ready (tx_payload_ready)
    );

    // Watches the outgoing payload only
    first_byte_led first_byte_led_i (
        .clock      (clock),
        .reset      (reset),
        .beat_valid (tx_payload_valid),
        .beat_ready (tx_payload_ready),
        .beat       (tx_payload),
        .led        (led)
    );

endmodule

// ==== logic/udp_hdr_pkg.sv ====
package udp_hdr_pkg;

    // Header as decoded by the receive side of the stack
    typedef struct packed {
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
    } udp_rx_hdr_t;

    // Reply header handed to the transmit side
    // Source IP, TTL and checksum come from the stack itself
    typedef struct packed {
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
    } udp_tx_hdr_t;

endpackage

// ==== logic/udp_port_filter.sv ====
`timescale 1ns/1ns

`include "udp_echo_cfg.svh"

module udp_port_filter (
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        hdr_valid,
    input  udp_hdr_pkg::udp_rx_hdr_t    hdr,
    output logic                        hdr_ready,

    input  logic                        payload_valid,
    input  byte_stream_pkg::byte_beat_t payload,
    output logic                        payload_ready,

    output logic                        reply_valid,
    output udp_hdr_pkg::udp_tx_hdr_t    reply,
    input  logic                        reply_ready,

    output logic                        pass_valid,
    output byte_stream_pkg::byte_beat_t pass_beat,
    input  logic                        pass_ready
);

    typedef enum logic [1:0] {
        state_idle,
        state_pass,
        state_drop
    } state_t;

    state_t state;
    logic   match;
    logic   hdr_fire;
    logic   payload_fire;

    assign match = (hdr.dest_port == `ECHO_PORT);

    // Non-matching headers never wait, matching ones need room for the reply
    assign hdr_ready   = (state == state_idle) && (!match || reply_ready);
    assign reply_valid = (state == state_idle) && hdr_valid && match;

    // Reply goes back where the frame came from
    assign reply.dest_ip     = hdr.source_ip;
    assign reply.source_port = hdr.dest_port;
    assign reply.dest_port   = hdr.source_port;
    assign reply.length      = hdr.length;

    // Payload steering follows the decision latched with the header
    always_comb begin
        case (state)
            state_pass: payload_ready = pass_ready;
            state_drop: payload_ready = 1'b1;
            default:    payload_ready = 1'b0;
        endcase
    end

    assign pass_valid = (state == state_pass) && payload_valid;
    assign pass_beat  = payload;

    assign hdr_fire     = hdr_valid && hdr_ready;
    assign payload_fire = payload_valid && payload_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            case (state)
                state_idle: begin
                    if (hdr_fire) begin
                        state <= match ? state_pass : state_drop;
                    end
                end
                state_pass, state_drop: begin
                    // Frame ends on its last beat
                    if (payload_fire && payload.last) begin
                        state <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // One header per frame until that frame's last beat is taken
    hdr_only_in_idle: assert property (@(posedge clock) disable iff (reset)
        hdr_fire |=> !hdr_fire until (payload_fire && payload.last))
        else $error("udp_port_filter: header accepted mid-frame");

    // Between frames no beat is taken before the next header
    no_beat_in_idle: assert property (@(posedge clock) disable iff (reset)
        payload_fire && payload.last |=> !payload_fire until hdr_fire)
        else $error("udp_port_filter: payload beat accepted in idle");

endmodule

// ==== sim.f ====
+incdir+include
logic/udp_hdr_pkg.sv
logic/byte_stream_pkg.sv
logic/stream_fifo.sv
logic/udp_port_filter.sv
logic/first_byte_led.sv
logic/udp_echo_top.sv
test/udp_echo_tb.sv

// ==== test/udp_echo_tb.sv ====
`timescale 1ns/1ns

`include "udp_echo_cfg.svh"

module udp_echo_tb;

    import udp_hdr_pkg::*;
    import byte_stream_pkg::*;

    localparam logic [31:0] SEED = 32'h2537ba19;
    localparam int RX_TIMEOUT    = 500;
    localparam int DRAIN_TIMEOUT = 3000;

    logic        clock, reset;
    logic        rx_hdr_valid, rx_hdr_ready, rx_payload_valid, rx_payload_ready;
    logic        tx_hdr_valid, tx_hdr_ready, tx_payload_valid, tx_payload_ready;
    udp_rx_hdr_t rx_hdr;
    udp_tx_hdr_t tx_hdr;
    byte_beat_t  rx_payload, tx_payload;
    logic [7:0]  led;

    udp_tx_hdr_t exp_hdr_q[$];
    byte_beat_t  exp_beat_q[$];
    logic [31:0] stim_state, ready_state;
    logic [31:0] pick_echo, pick_len;
    logic        random_ready, hdr_fire_seen, beat_fire_seen, frame_start;
    logic [7:0]  led_expected;
    logic [7:0]  last_first_byte;
    int          error_count, tests_run, errors_before;

    udp_echo_top udp_echo_top_i (.*);

    always #50 clock = ~clock;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    // Random transmit back-pressure, own generator state
    always @(posedge clock) begin
        if (random_ready) begin
            #10;
            ready_state      = lcg_step(ready_state);
            tx_hdr_ready     = ready_state[27];
            tx_payload_ready = ready_state[21] | ready_state[13];
        end
    end

    // Expected items leave their queues half a cycle after the transfer
    always @(posedge clock) begin
        hdr_fire_seen  <= !reset && tx_hdr_valid && tx_hdr_ready;
        beat_fire_seen <= !reset && tx_payload_valid && tx_payload_ready;
        if (reset) begin
            frame_start <= 1'b1;
        end else if (tx_payload_valid && tx_payload_ready && exp_beat_q.size() != 0) begin
            // First byte of the reply frame this transfer opens
            if (frame_start) begin
                led_expected <= exp_beat_q[0].data;
            end
            frame_start <= exp_beat_q[0].last;
        end
    end

    always @(negedge clock) begin
        if (hdr_fire_seen && exp_hdr_q.size() != 0) begin
            void'(exp_hdr_q.pop_front());
        end
        if (beat_fire_seen && exp_beat_q.size() != 0) begin
            void'(exp_beat_q.pop_front());
        end
    end

    reset_state: assert property (@(posedge clock)
        $fell(reset) |-> !tx_hdr_valid && !tx_payload_valid && !rx_payload_ready && led == 8'h00)
        else begin
            error_count++;
            $write("Error after reset: tx_hdr_valid %h tx_payload_valid %h",
                $sampled(tx_hdr_valid), $sampled(tx_payload_valid));
            $display(" rx_payload_ready %h led %h",
                $sampled(rx_payload_ready), $sampled(led));
        end

    hdr_expected: assert property (@(posedge clock) disable iff (reset)
        tx_hdr_valid && tx_hdr_ready |-> exp_hdr_q.size() != 0)
        else begin
            error_count++;
            $display("A reply header was sent that no echo frame asked for");
        end

    hdr_value: assert property (@(posedge clock) disable iff (reset)
        tx_hdr_valid && tx_hdr_ready && exp_hdr_q.size() != 0 |-> tx_hdr == exp_hdr_q[0])
        else begin
            error_count++;
            $display("Error tx_hdr: got %h, expected %h", $sampled(tx_hdr), exp_hdr_q[0]);
        end

    beat_expected: assert property (@(posedge clock) disable iff (reset)
        tx_payload_valid && tx_payload_ready |-> exp_beat_q.size() != 0)
        else begin
            error_count++;
            $display("A payload byte was sent that no echo frame asked for");
        end

    beat_value: assert property (@(posedge clock) disable iff (reset)
        tx_payload_valid && tx_payload_ready && exp_beat_q.size() != 0
        |-> tx_payload == exp_beat_q[0])
        else begin
            error_count++;
            $display("Error tx_payload: got %h, expected %h", $sampled(tx_payload), exp_beat_q[0]);
        end

    led_value: assert property (@(posedge clock) disable iff (reset)
        tx_payload_valid && tx_payload_ready && frame_start && exp_beat_q.size() != 0
        |=> led == led_expected)
        else begin
            error_count++;
            $display("Error led: got %h, expected %h", $sampled(led), $sampled(led_expected));
        end

    task automatic finish_run();
        $display("Tests run: %0d, errors: %0d", tests_run, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        error_count++;
        $display("Timeout: %s", what);
        finish_run();
    endtask

    // Returns at rising edge plus 10 ns, after the item has been taken
    task automatic wait_rx_ready(input logic is_hdr);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!(is_hdr ? rx_hdr_ready : rx_payload_ready)) begin
            cycles++;
            if (cycles > RX_TIMEOUT) begin
                abort_on_timeout(is_hdr ? "rx_hdr was never accepted" :
                                          "rx_payload beat was never accepted");
            end
            @(negedge clock);
        end
        @(posedge clock);
        #10;
    endtask

    task automatic send_frame(input logic echo, input int len);
        udp_rx_hdr_t h;
        udp_tx_hdr_t r;
        byte_beat_t  b;
        logic [31:0] x;
        h.source_ip = next_rand();
        h.dest_ip   = next_rand();
        x = next_rand();
        h.source_port = x[31:16];
        h.dest_port   = echo ? `ECHO_PORT : x[15:0];
        if (!echo && h.dest_port == `ECHO_PORT) begin
            h.dest_port = h.dest_port ^ 16'h0001;
        end
        h.length = 16'(len + 8);
        // Reply goes back to the sender with the ports swapped
        if (echo) begin
            r.dest_ip     = h.source_ip;
            r.source_port = h.dest_port;
            r.dest_port   = h.source_port;
            r.length      = h.length;
            exp_hdr_q.push_back(r);
        end
        rx_hdr       = h;
        rx_hdr_valid = 1'b1;
        wait_rx_ready(1'b1);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            x = next_rand();
            b.data = x[23:16];
            b.user = x[9];
            b.last = (i == len - 1);
            if (echo) begin
                exp_beat_q.push_back(b);
                if (i == 0) begin
                    last_first_byte = b.data;
                end
            end
            rx_payload       = b;
            rx_payload_valid = 1'b1;
            wait_rx_ready(1'b0);
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                abort_on_timeout("expected reply frames never left the DUT");
            end
            @(negedge clock);
        end
        repeat (4) @(posedge clock);
        #10;
    endtask

    task automatic wait_stall();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!(rx_payload_valid && !rx_payload_ready)) begin
            cycles++;
            if (cycles > RX_TIMEOUT) begin
                abort_on_timeout("rx_payload_ready never dropped with the payload queue full");
            end
            @(negedge clock);
        end
        @(posedge clock);
        #10;
        tx_payload_ready = 1'b1;
    endtask

    task automatic report_test(input int num, input string name);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_hdr = '0;
        rx_payload_valid = 1'b0;
        rx_payload = '0;
        tx_hdr_ready = 1'b1;
        tx_payload_ready = 1'b1;
        random_ready = 1'b0;
        stim_state = SEED;
        ready_state = SEED ^ 32'h5a5a5a5a;
        last_first_byte = 8'h00;
        error_count = 0;
        tests_run = 0;
        errors_before = 0;

        repeat (4) @(posedge clock);
        #10;
        reset = 1'b0;
        repeat (2) @(posedge clock);
        #10;
        report_test(1, "after reset");

        send_frame(1'b1, 12);
        wait_drain();
        report_test(2, "echo frame");

        send_frame(1'b0, 15);
        wait_drain();
        report_test(3, "dropped frame");

        random_ready = 1'b1;
        for (int n = 0; n < 12; n++) begin
            pick_echo = next_rand();
            pick_len  = next_rand();
            send_frame(pick_echo[28], 1 + int'(pick_len[20:16]) % 20);
        end
        random_ready = 1'b0;
        @(posedge clock);
        #10;
        tx_hdr_ready = 1'b1;
        tx_payload_ready = 1'b1;
        wait_drain();
        report_test(4, "mixed frames under back-pressure");

        tx_payload_ready = 1'b0;
        fork
            send_frame(1'b1, 80);
            wait_stall();
        join
        wait_drain();
        report_test(5, "full payload queue");

        for (int n = 0; n < 3; n++) begin
            send_frame(1'b1, 1 + n * 3);
        end
        wait_drain();
        led_final: assert (led == last_first_byte)
            else begin
                error_count++;
                $display("Error led: got %h, expected %h", led, last_first_byte);
            end
        report_test(6, "led first byte");

        finish_run();
    end

endmodule
